//--- project.f
+incdir+.
rv_pkg.sv
exec_bus_if.sv
alu.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
rv_int_pipe.sv
tb_rv_int_pipe.sv

//--- run_sim.sh
#!/bin/sh
# build and run the integer pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_int_pipe -f project.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb_rv_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module tb_rv_int_pipe;

    import rv_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      i_instr_valid;
    instr_t    i_instr;
    logic      o_retire_valid;
    reg_addr_t o_retire_rd;
    xlen_t     o_retire_data;

    // reference register model and expected retires, in issue order
    xlen_t       model_rf [0:31];
    reg_addr_t   exp_rd_q[$];
    xlen_t       exp_data_q[$];
    logic [31:0] lcg_state;

    rv_int_pipe dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // error reporting and compares
    //////////////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_data(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            report_error("data compare failed");
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got x%0d, expected x%0d", $time, what, got, exp);
            report_error("register index compare failed");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
            report_error("flag compare failed");
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // result by the RV32I rules, alt is instr bit 30
    function automatic xlen_t ref_alu(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_imm,
        input xlen_t      a,
        input xlen_t      b
    );
        xlen_t      r;
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            `RV_F3_ADD_SUB: r = (alt && !is_imm) ? a - b : a + b;
            `RV_F3_SLL:     r = a << sh;
            // signs differ, the negative one is smaller
            `RV_F3_SLT:     r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            `RV_F3_SLTU:    r = {31'd0, a < b};
            `RV_F3_XOR:     r = a ^ b;
            `RV_F3_SRL_SRA:
            begin
                r = a >> sh;
                // fill vacated high bits with the sign
                if (alt && a[31])
                    r = r | ~(32'hffff_ffff >> sh);
            end
            `RV_F3_OR:      r = a | b;
            `RV_F3_AND:     r = a & b;
            default:        r = '0;
        endcase
        return r;
    endfunction

    task automatic expect_retire(input reg_addr_t rd, input xlen_t data);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
        if (rd != 5'd0)
            model_rf[rd] = data;
    endtask

    // one-cycle strobe, entered and left 2 ns after a rising edge
    task automatic send_word(input instr_t word);
        i_instr_valid = 1'b1;
        i_instr       = word;
        @(posedge clk);
        #2;
        i_instr_valid = 1'b0;
    endtask

    task automatic issue_op(
        input logic [2:0] f3,
        input logic       alt,
        input reg_addr_t  rd,
        input reg_addr_t  rs1,
        input reg_addr_t  rs2
    );
        instr_t word;
        word = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, `RV_OPCODE_OP};
        expect_retire(rd, ref_alu(f3, alt, 1'b0, model_rf[rs1], model_rf[rs2]));
        send_word(word);
    endtask

    task automatic issue_imm(
        input logic [2:0]  f3,
        input reg_addr_t   rd,
        input reg_addr_t   rs1,
        input logic [11:0] imm
    );
        instr_t word;
        xlen_t  b;
        word = {imm, rs1, f3, rd, `RV_OPCODE_OP_IMM};
        b    = {{20{imm[11]}}, imm};
        expect_retire(rd, ref_alu(f3, imm[10], 1'b1, model_rf[rs1], b));
        send_word(word);
    endtask

    task automatic issue_lui(input reg_addr_t rd, input logic [19:0] imm);
        expect_retire(rd, {imm, 12'h000});
        send_word({imm, rd, `RV_OPCODE_LUI});
    endtask

    // shift immediate field, alt selects arithmetic right shift
    function automatic logic [11:0] shift_imm(input logic alt, input logic [4:0] shamt);
        return {1'b0, alt, 5'b00000, shamt};
    endfunction

    // pops the expected queue on every retire
    always @(negedge clk)
    begin
        if (rst_n && o_retire_valid)
        begin
            if (exp_rd_q.size() == 0)
                report_error("a retire came out with no instruction outstanding");
            else
            begin
                check_reg("retire rd", o_retire_rd, exp_rd_q[0]);
                check_data("retire data", o_retire_data, exp_data_q[0]);
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // waits
    //////////////////////////////////////////////////

    task automatic wait_first_retire();
        int n;
        n = 0;
        @(negedge clk);
        while (!o_retire_valid)
        begin
            n++;
            if (n > 20)
                report_error("timed out waiting for the first retire");
            @(negedge clk);
        end
    endtask

    // retires on consecutive cycles, no gap allowed
    task automatic expect_burst(input int count);
        wait_first_retire();
        repeat (count - 1)
        begin
            @(negedge clk);
            check_flag("retire valid inside burst", o_retire_valid, 1'b1);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rd_q.size() != 0)
        begin
            @(negedge clk);
            n++;
            if (n > 40)
                report_error("timed out waiting for outstanding retires");
        end
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            check_flag("retire valid while idle", o_retire_valid, 1'b0);
        end
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_first_retire();
        idle_cycles(4);
        issue_imm(`RV_F3_ADD_SUB, 5'd1, 5'd0, 12'd5);
        // sampling edge just passed, retire in the cycle after its third edge
        @(negedge clk);
        check_flag("retire valid one edge after sampling", o_retire_valid, 1'b0);
        @(negedge clk);
        check_flag("retire valid two edges after sampling", o_retire_valid, 1'b0);
        @(negedge clk);
        check_flag("retire valid three edges after sampling", o_retire_valid, 1'b1);
        check_reg("first retire rd", o_retire_rd, 5'd1);
        check_data("first retire data", o_retire_data, 32'd5);
        wait_drain();
    endtask

    task automatic test_reg_reg_ops();
        // x1 negative, x2 small positive, x3 mixed bits
        issue_lui(5'd1, 20'hfffff);
        issue_imm(`RV_F3_ADD_SUB, 5'd1, 5'd1, 12'h123);
        issue_imm(`RV_F3_ADD_SUB, 5'd2, 5'd0, 12'h035);
        issue_lui(5'd3, 20'h12345);
        issue_imm(`RV_F3_ADD_SUB, 5'd3, 5'd3, 12'h678);
        issue_op(`RV_F3_ADD_SUB, 1'b0, 5'd10, 5'd1, 5'd2);
        issue_op(`RV_F3_ADD_SUB, 1'b1, 5'd11, 5'd2, 5'd1);
        issue_op(`RV_F3_SLL, 1'b0, 5'd12, 5'd3, 5'd2);
        issue_op(`RV_F3_SLT, 1'b0, 5'd13, 5'd1, 5'd2);
        issue_op(`RV_F3_SLT, 1'b0, 5'd14, 5'd2, 5'd1);
        issue_op(`RV_F3_SLTU, 1'b0, 5'd15, 5'd1, 5'd2);
        issue_op(`RV_F3_SLTU, 1'b0, 5'd16, 5'd2, 5'd1);
        issue_op(`RV_F3_XOR, 1'b0, 5'd17, 5'd1, 5'd3);
        issue_op(`RV_F3_SRL_SRA, 1'b0, 5'd18, 5'd1, 5'd2);
        issue_op(`RV_F3_SRL_SRA, 1'b1, 5'd19, 5'd1, 5'd2);
        issue_op(`RV_F3_OR, 1'b0, 5'd20, 5'd2, 5'd3);
        issue_op(`RV_F3_AND, 1'b0, 5'd21, 5'd1, 5'd3);
        wait_drain();
    endtask

    task automatic test_reg_imm_ops();
        issue_imm(`RV_F3_ADD_SUB, 5'd20, 5'd1, 12'hfff);
        issue_imm(`RV_F3_SLT, 5'd21, 5'd1, 12'hffb);
        issue_imm(`RV_F3_SLTU, 5'd22, 5'd2, 12'hfff);
        issue_imm(`RV_F3_XOR, 5'd23, 5'd3, 12'hfff);
        issue_imm(`RV_F3_OR, 5'd24, 5'd2, 12'h7f0);
        issue_imm(`RV_F3_AND, 5'd25, 5'd3, 12'h0ff);
        issue_imm(`RV_F3_SLL, 5'd26, 5'd3, shift_imm(1'b0, 5'd7));
        issue_imm(`RV_F3_SRL_SRA, 5'd27, 5'd1, shift_imm(1'b0, 5'd13));
        issue_imm(`RV_F3_SRL_SRA, 5'd28, 5'd1, shift_imm(1'b1, 5'd13));
        issue_lui(5'd29, 20'habcde);
        wait_drain();
    endtask

    task automatic test_forwarding_chains();
        fork
            begin
                // distance one, 5 instructions
                issue_imm(`RV_F3_ADD_SUB, 5'd5, 5'd0, 12'd1);
                repeat (4)
                    issue_op(`RV_F3_ADD_SUB, 1'b0, 5'd5, 5'd5, 5'd5);
                // distance two, 8 instructions
                issue_imm(`RV_F3_ADD_SUB, 5'd6, 5'd0, 12'd3);
                issue_imm(`RV_F3_ADD_SUB, 5'd7, 5'd0, 12'd10);
                repeat (3)
                begin
                    issue_op(`RV_F3_ADD_SUB, 1'b1, 5'd6, 5'd6, 5'd7);
                    issue_op(`RV_F3_XOR, 1'b0, 5'd7, 5'd7, 5'd6);
                end
                // distance three, 9 instructions
                issue_imm(`RV_F3_ADD_SUB, 5'd8, 5'd0, 12'd7);
                issue_lui(5'd9, 20'h00010);
                issue_imm(`RV_F3_ADD_SUB, 5'd10, 5'd0, 12'hffe);
                repeat (2)
                begin
                    issue_op(`RV_F3_ADD_SUB, 1'b0, 5'd8, 5'd8, 5'd10);
                    issue_op(`RV_F3_OR, 1'b0, 5'd9, 5'd9, 5'd8);
                    issue_imm(`RV_F3_SRL_SRA, 5'd10, 5'd10, shift_imm(1'b1, 5'd1));
                end
            end
            expect_burst(22);
        join
        wait_drain();
    endtask

    task automatic test_x0_and_bubbles();
        // x0 write still retires, but x0 stays zero
        issue_imm(`RV_F3_ADD_SUB, 5'd0, 5'd0, 12'h007);
        issue_op(`RV_F3_ADD_SUB, 1'b0, 5'd11, 5'd0, 5'd0);
        issue_imm(`RV_F3_OR, 5'd12, 5'd0, 12'h000);
        wait_drain();
        // branch and load opcodes give no retire
        send_word(32'h0000_0063);
        send_word({12'h000, 5'd0, 3'b010, 5'd13, 7'b0000011});
        idle_cycles(2);
        issue_op(`RV_F3_ADD_SUB, 1'b0, 5'd14, 5'd13, 5'd0);
        wait_drain();
        idle_cycles(6);
    endtask

    task automatic random_instr();
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        r   = lcg_next();
        f3  = r[2:0];
        rd  = {2'b00, r[5:3]};
        rs1 = {2'b00, r[8:6]};
        rs2 = {2'b00, r[11:9]};
        alt = r[14];
        case (r[13:12])
            2'd2:
            begin
                if (f3 == `RV_F3_SLL || f3 == `RV_F3_SRL_SRA)
                    issue_imm(f3, rd, rs1, shift_imm(alt && f3 == `RV_F3_SRL_SRA, r[19:15]));
                else
                    issue_imm(f3, rd, rs1, r[31:20]);
            end
            2'd3:
                issue_lui(rd, r[31:12]);
            default:
                issue_op(f3, alt && (f3 == `RV_F3_ADD_SUB || f3 == `RV_F3_SRL_SRA),
                         rd, rs1, rs2);
        endcase
    endtask

    task automatic test_random_stream();
        fork
            repeat (60)
                random_instr();
            expect_burst(60);
        join
        wait_drain();
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        rst_n         = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        lcg_state     = 32'hde0c_07fc;
        for (int i = 0; i < 32; i++)
            model_rf[i] = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_first_retire();
        test_reg_reg_ops();
        test_reg_imm_ops();
        test_forwarding_chains();
        test_x0_and_bubbles();
        test_random_stream();

        if (exp_rd_q.size() != 0)
            report_error("expected retires were still outstanding at the end");
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // hard limit on run length
    initial
    begin
        #200000;
        report_error("simulation ran past its time limit");
    end

endmodule

`default_nettype wire

//--- rv_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module rv_int_pipe (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_instr_valid,
    input  rv_pkg::instr_t      i_instr,
    output logic                o_retire_valid,
    output rv_pkg::reg_addr_t   o_retire_rd,
    output rv_pkg::xlen_t       o_retire_data
);

    import rv_pkg::*;

    // register file port between decode and writeback
    rf_read_t  rf_read;
    rf_data_t  rf_data;

    // execute -> writeback retire
    logic      ex_retire_valid;
    reg_addr_t ex_retire_rd;
    xlen_t     ex_retire_data;

    exec_bus_if exec_bus ();

    //////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////

    decode_stage u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_rf_read     (rf_read),
        .i_rf_data     (rf_data),
        .o_exec        (exec_bus.decode)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_exec         (exec_bus.execute),
        .o_retire_valid (ex_retire_valid),
        .o_retire_rd    (ex_retire_rd),
        .o_retire_data  (ex_retire_data)
    );

    writeback_stage u_writeback (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_retire_valid (ex_retire_valid),
        .i_retire_rd    (ex_retire_rd),
        .i_retire_data  (ex_retire_data),
        .i_rf_read      (rf_read),
        .o_rf_data      (rf_data),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

endmodule

`default_nettype wire

//--- writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module writeback_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_retire_valid,
    input  rv_pkg::reg_addr_t   i_retire_rd,
    input  rv_pkg::xlen_t       i_retire_data,
    input  rv_pkg::rf_read_t    i_rf_read,
    output rv_pkg::rf_data_t    o_rf_data,
    output logic                o_retire_valid,
    output rv_pkg::reg_addr_t   o_retire_rd,
    output rv_pkg::xlen_t       o_retire_data
);

    import rv_pkg::*;

    localparam int num_regs = 2 ** `RV_REG_ADDR_W;

    // x1..x31, x0 has no storage
    xlen_t rf [1:num_regs-1];
    logic  wr_en;

    // read one port with write-first bypass
    function automatic xlen_t rd_port(
        input reg_addr_t addr,
        input xlen_t     stored
    );
        xlen_t val;
        if (addr == '0)
            val = '0;
        else if (wr_en && i_retire_rd == addr)
            val = i_retire_data;
        else
            val = stored;
        return val;
    endfunction

    // x0 writes dropped here
    assign wr_en = i_retire_valid && (i_retire_rd != '0);

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////

    // written at the edge that closes the retire cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < num_regs; i++)
                rf[i] <= '0;
        end
        else if (wr_en)
        begin
            rf[i_retire_rd] <= i_retire_data;
        end
    end

    // distance two hazard resolved by the bypass
    always_comb
    begin
        o_rf_data.rs1_data = rd_port(i_rf_read.rs1, rf[i_rf_read.rs1]);
        o_rf_data.rs2_data = rd_port(i_rf_read.rs2, rf[i_rf_read.rs2]);
    end

    // retire triple out to the top
    assign o_retire_valid = i_retire_valid;
    assign o_retire_rd    = i_retire_rd;
    assign o_retire_data  = i_retire_data;

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    exec_bus_if.execute         i_exec,
    output logic                o_retire_valid,
    output rv_pkg::reg_addr_t   o_retire_rd,
    output rv_pkg::xlen_t       o_retire_data
);

    import rv_pkg::*;

    // result register
    logic      res_valid;
    reg_addr_t res_rd;
    xlen_t     res_data;

    // forwarding hits
    logic      fwd_a;
    logic      fwd_b;

    // alu operands and output
    xlen_t     op_a;
    xlen_t     op_b;
    xlen_t     alu_out;

    //////////////////////////////////////////////////
    // forwarding
    //////////////////////////////////////////////////

    // distance one, producer sits in the result register
    // x0 never forwards
    assign fwd_a = res_valid && (res_rd != '0) && (res_rd == i_exec.rs1);
    assign fwd_b = res_valid && (res_rd != '0) && (res_rd == i_exec.rs2);

    assign op_a = fwd_a ? res_data : i_exec.rs1_data;

    // immediate wins over rs2, rs2 field may be imm bits
    always_comb
    begin
        if (i_exec.use_imm)
            op_b = i_exec.imm;
        else if (fwd_b)
            op_b = res_data;
        else
            op_b = i_exec.rs2_data;
    end

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////

    alu u_alu (
        .i_op     (i_exec.alu_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .o_result (alu_out)
    );

    //////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= i_exec.valid;
    end

    // payload, qualified by res_valid
    always_ff @(posedge clk)
    begin
        res_rd   <= i_exec.rd;
        res_data <= alu_out;
    end

    // retire straight from the result register
    assign o_retire_valid = res_valid;
    assign o_retire_rd    = res_rd;
    assign o_retire_data  = res_data;

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_instr_valid,
    input  rv_pkg::instr_t      i_instr,
    output rv_pkg::rf_read_t    o_rf_read,
    input  rv_pkg::rf_data_t    i_rf_data,
    exec_bus_if.decode          o_exec
);

    import rv_pkg::*;

    // capture register
    logic        cap_valid;
    instr_t      cap_instr;

    // decoded fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        dec_supported;
    logic        dec_use_imm;
    alu_op_e     dec_op;
    xlen_t       dec_imm;

    // funct3 -> alu op
    // sub_sel only meaningful for OP, sra_sel for both
    function automatic alu_op_e f3_to_op(
        input logic [2:0] f3,
        input logic       sub_sel,
        input logic       sra_sel
    );
        alu_op_e op;
        case (f3)
            `RV_F3_ADD_SUB: op = sub_sel ? alu_sub : alu_add;
            `RV_F3_SLL:     op = alu_sll;
            `RV_F3_SLT:     op = alu_slt;
            `RV_F3_SLTU:    op = alu_sltu;
            `RV_F3_XOR:     op = alu_xor;
            `RV_F3_SRL_SRA: op = sra_sel ? alu_sra : alu_srl;
            `RV_F3_OR:      op = alu_or;
            default:        op = alu_and;
        endcase
        return op;
    endfunction

    //////////////////////////////////////////////////
    // instruction capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cap_valid <= 1'b0;
        else
            cap_valid <= i_instr_valid;
    end

    // word only loads on a strobe
    always_ff @(posedge clk)
    begin
        if (i_instr_valid)
            cap_instr <= i_instr;
    end

    assign opcode = cap_instr[6:0];
    assign funct3 = cap_instr[14:12];

    // register file read indices, data comes back same cycle
    assign o_rf_read.rs1 = cap_instr[19:15];
    assign o_rf_read.rs2 = cap_instr[24:20];

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    always_comb
    begin
        dec_supported = 1'b1;
        dec_use_imm   = 1'b0;
        dec_op        = alu_add;
        dec_imm       = '0;
        case (opcode)
            `RV_OPCODE_OP:
            begin
                // funct7 bit 5 selects sub / sra
                dec_op = f3_to_op(funct3, cap_instr[30], cap_instr[30]);
            end
            `RV_OPCODE_OP_IMM:
            begin
                dec_use_imm = 1'b1;
                // no SUBI, bit 30 is immediate data for ADDI
                dec_op      = f3_to_op(funct3, 1'b0, cap_instr[30]);
                if (funct3 == `RV_F3_SLL || funct3 == `RV_F3_SRL_SRA)
                    dec_imm = {{(`RV_XLEN-5){1'b0}}, cap_instr[24:20]};
                else
                    dec_imm = {{(`RV_XLEN-12){cap_instr[31]}}, cap_instr[31:20]};
            end
            `RV_OPCODE_LUI:
            begin
                dec_use_imm = 1'b1;
                dec_op      = alu_pass_b;
                // upper 20 bits, low 12 zero
                dec_imm     = {cap_instr[31:12], 12'b0};
            end
            default:
            begin
                // anything else turns into a bubble
                dec_supported = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // exec bus register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            o_exec.valid <= 1'b0;
        else
            o_exec.valid <= cap_valid && dec_supported;
    end

    always_ff @(posedge clk)
    begin
        o_exec.alu_op   <= dec_op;
        o_exec.rd       <= cap_instr[11:7];
        o_exec.rs1      <= cap_instr[19:15];
        o_exec.rs2      <= cap_instr[24:20];
        o_exec.use_imm  <= dec_use_imm;
        o_exec.imm      <= dec_imm;
        // already bypassed against the retiring write
        o_exec.rs1_data <= i_rf_data.rs1_data;
        o_exec.rs2_data <= i_rf_data.rs2_data;
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::alu_op_e i_op,
    input  rv_pkg::xlen_t   i_a,
    input  rv_pkg::xlen_t   i_b,
    output rv_pkg::xlen_t   o_result
);

    import rv_pkg::*;

    // shift amount, low five bits of b
    logic [4:0] shamt;
    // compare results
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    //////////////////////////////////////////////////
    // operation select
    //////////////////////////////////////////////////

    always_comb
    begin
        case (i_op)
            alu_add:
                o_result = i_a + i_b;
            alu_sub:
                o_result = i_a - i_b;
            alu_sll:
                o_result = i_a << shamt;
            // set-less-than gives 0 or 1
            alu_slt:
                o_result = {{($bits(xlen_t)-1){1'b0}}, lt_signed};
            alu_sltu:
                o_result = {{($bits(xlen_t)-1){1'b0}}, lt_unsigned};
            alu_xor:
                o_result = i_a ^ i_b;
            alu_srl:
                o_result = i_a >> shamt;
            // sign bit fills from the left
            alu_sra:
                o_result = xlen_t'($signed(i_a) >>> shamt);
            alu_or:
                o_result = i_a | i_b;
            alu_and:
                o_result = i_a & i_b;
            // LUI path, a ignored
            alu_pass_b:
                o_result = i_b;
            default:
                o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- exec_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// decode -> execute bus
// one instruction per cycle with valid high
// no ready and no back-pressure
interface exec_bus_if;

    import rv_pkg::*;

    // instruction present this cycle
    logic      valid;
    // decoded alu operation
    alu_op_e   alu_op;

    // register indices
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;

    // operand b from imm instead of rs2
    logic      use_imm;
    xlen_t     imm;

    // register file values seen in decode
    // execute replaces them when its result register matches
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    // decode side drives everything
    modport decode (
        output valid,
        output alu_op,
        output rd,
        output rs1,
        output rs2,
        output use_imm,
        output imm,
        output rs1_data,
        output rs2_data
    );

    // execute side only samples
    modport execute (
        input valid,
        input alu_op,
        input rd,
        input rs1,
        input rs2,
        input use_imm,
        input imm,
        input rs1_data,
        input rs2_data
    );

endinterface

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    //////////////////////////////////////////////////
    // scalar types
    //////////////////////////////////////////////////

    // one data word
    typedef logic [`RV_XLEN-1:0] xlen_t;

    // register index
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // raw instruction word, fixed by the ISA
    typedef logic [31:0] instr_t;

    // alu operation select
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // operand b straight through, for LUI
        alu_pass_b = 4'd10
    } alu_op_e;

    //////////////////////////////////////////////////
    // register file read port
    //////////////////////////////////////////////////

    // indices, decode to writeback
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
    } rf_read_t;

    // read data, writeback back to decode
    typedef struct packed {
        xlen_t rs1_data;
        xlen_t rs2_data;
    } rf_data_t;

endpackage

`default_nettype wire

//--- rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// data path width
`define RV_XLEN             32
// register index, x0..x31
`define RV_REG_ADDR_W       5

//////////////////////////////////////////////////
// major opcodes, instr[6:0]
//////////////////////////////////////////////////

`define RV_OPCODE_OP        7'b0110011
`define RV_OPCODE_OP_IMM    7'b0010011
`define RV_OPCODE_LUI       7'b0110111

//////////////////////////////////////////////////
// funct3 codes, instr[14:12]
//////////////////////////////////////////////////

// same code for OP and OP-IMM
`define RV_F3_ADD_SUB       3'b000
`define RV_F3_SLL           3'b001
`define RV_F3_SLT           3'b010
`define RV_F3_SLTU          3'b011
`define RV_F3_XOR           3'b100
// instr[30] picks arithmetic shift
`define RV_F3_SRL_SRA       3'b101
`define RV_F3_OR            3'b110
`define RV_F3_AND           3'b111

`endif
